//--- src/iss_pkg.sv
package iss_pkg;

  // issue geometry
  localparam int issue_width = 2;
  localparam int data_w      = 32;
  localparam int reg_addr_w  = 5;
  localparam int rob_idx_w   = 4;

  // holds 0 to issue_width
  localparam int pop_w = 2;

  // link value is the return address after the delay slot
  localparam int link_offset = 8;

  // instruction class as produced by the decoder
  typedef enum logic [2:0] {
    op_alu    = 3'd0,
    op_load   = 3'd1,
    op_store  = 3'd2,
    op_muldiv = 3'd3,
    op_branch = 3'd4,
    op_jump   = 3'd5
  } op_class_e;

  // branch condition, evaluated on operand a (and b for eq/ne)
  typedef enum logic [2:0] {
    cond_uncond = 3'd0,
    cond_eq     = 3'd1,
    cond_ne     = 3'd2,
    cond_gt     = 3'd3,
    cond_ge     = 3'd4,
    cond_lt     = 3'd5,
    cond_le     = 3'd6
  } branch_cond_e;

  // decoded instruction, one per queue entry
  typedef struct packed {
    logic [data_w-1:0]     pc;
    logic [data_w-1:0]     branch_target;
    op_class_e             op_class;
    branch_cond_e          branch_cond;
    // jr/jalr style, target comes from register a
    logic                  rformat;
    logic [reg_addr_w-1:0] a_reg;
    logic                  a_reg_valid;
    logic [reg_addr_w-1:0] b_reg;
    logic                  b_reg_valid;
    logic [reg_addr_w-1:0] dest_reg;
    logic                  dest_reg_valid;
  } dec_inst_t;

  // result write into a ROB slot
  typedef struct packed {
    logic [data_w-1:0]     result;
    logic [reg_addr_w-1:0] dest_reg;
    logic                  dest_reg_valid;
    logic                  pc_valid;
  } rob_entry_t;

  // payload handed to an execution unit
  typedef struct packed {
    dec_inst_t             inst;
    logic [data_w-1:0]     a;
    logic [data_w-1:0]     b;
    logic [rob_idx_w-1:0]  rob_slot;
  } unit_issue_t;

endpackage

//--- src/operand_if.sv
`timescale 1ns/1ns

// resolved operands for every slot the selector looks at
interface operand_if import iss_pkg::*; ();

  dec_inst_t            inst     [issue_width];
  logic [rob_idx_w-1:0] rob_slot [issue_width];
  logic [data_w-1:0]    a        [issue_width];
  logic [data_w-1:0]    b        [issue_width];
  // all used operands are available
  logic                 ops_ready [issue_width];

  modport resolver (
    output inst, rob_slot, a, b, ops_ready
  );

  modport selector (
    input  inst, rob_slot, a, b, ops_ready
  );

endinterface

//--- src/branch_if.sv
`timescale 1ns/1ns

// single branch issue port
interface branch_if import iss_pkg::*; ();

  logic                 valid;
  dec_inst_t            inst;
  logic [data_w-1:0]    a;
  logic [data_w-1:0]    b;
  logic [rob_idx_w-1:0] rob_slot;
  // low for one cycle after a fetch stall
  logic                 ready;

  modport selector (
    output valid, inst, a, b, rob_slot,
    input  ready
  );

  modport branch (
    input  valid, inst, a, b, rob_slot,
    output ready
  );

endinterface

//--- src/operand_resolve.sv
`timescale 1ns/1ns

module operand_resolve import iss_pkg::*; (
  input  dec_inst_t             iq_inst       [issue_width],
  input  logic [rob_idx_w-1:0]  iq_rob_slot   [issue_width],

  // ROB associative lookup, one result per operand
  input  logic                  rob_present_a [issue_width],
  input  logic                  rob_present_b [issue_width],
  input  logic                  rob_valid_a   [issue_width],
  input  logic                  rob_valid_b   [issue_width],
  input  logic [data_w-1:0]     rob_value_a   [issue_width],
  input  logic [data_w-1:0]     rob_value_b   [issue_width],

  // register file, a and b ports interleaved per slot
  output logic [reg_addr_w-1:0] rf_addr       [2*issue_width],
  input  logic [data_w-1:0]     rf_data       [2*issue_width],

  operand_if.resolver           ops
);

  for (genvar i = 0; i < issue_width; i++) begin : g_slot
    logic a_avail;
    logic b_avail;

    assign rf_addr[2*i]   = iq_inst[i].a_reg;
    assign rf_addr[2*i+1] = iq_inst[i].b_reg;

    assign ops.inst[i]     = iq_inst[i];
    assign ops.rob_slot[i] = iq_rob_slot[i];

    // a ROB hit is newer than the register file
    assign ops.a[i] = rob_present_a[i] ? rob_value_a[i] : rf_data[2*i];
    assign ops.b[i] = rob_present_b[i] ? rob_value_b[i] : rf_data[2*i+1];

    // not in flight, or in flight and already written back
    assign a_avail = ~rob_present_a[i] | rob_valid_a[i];
    assign b_avail = ~rob_present_b[i] | rob_valid_b[i];

    // operands the instruction does not read never hold it back
    assign ops.ops_ready[i] = (a_avail | ~iq_inst[i].a_reg_valid)
                            & (b_avail | ~iq_inst[i].b_reg_valid);
  end

endmodule

//--- src/issue_select.sv
`timescale 1ns/1ns

module issue_select import iss_pkg::*; (
  input  logic             iq_valid [issue_width],

  input  logic             ls_ready,
  input  logic             alu_ready,
  input  logic             mul_ready,

  output unit_issue_t      ls_issue,
  output logic             ls_valid,
  output unit_issue_t      alu_issue,
  output logic             alu_valid,
  output unit_issue_t      mul_issue,
  output logic             mul_valid,

  // entries removed from the queue at the next edge
  output logic [pop_w-1:0] iq_pop,

  operand_if.selector      ops,
  branch_if.selector       br
);

  function automatic unit_issue_t pack_issue(
    input dec_inst_t            inst,
    input logic [data_w-1:0]    a,
    input logic [data_w-1:0]    b,
    input logic [rob_idx_w-1:0] rob_slot
  );
    unit_issue_t u;
    u.inst     = inst;
    u.a        = a;
    u.b        = b;
    u.rob_slot = rob_slot;
    return u;
  endfunction

  always_comb begin
    logic             done;
    logic             ls_used;
    logic             alu_used;
    logic             mul_used;
    logic             br_used;
    logic [pop_w-1:0] count;
    unit_issue_t      slot_issue;

    done     = 1'b0;
    ls_used  = 1'b0;
    alu_used = 1'b0;
    mul_used = 1'b0;
    br_used  = 1'b0;
    count    = '0;

    // payloads default to the oldest slot, only the valids matter
    slot_issue  = pack_issue(ops.inst[0], ops.a[0], ops.b[0], ops.rob_slot[0]);
    ls_issue    = slot_issue;
    alu_issue   = slot_issue;
    mul_issue   = slot_issue;
    br.inst     = ops.inst[0];
    br.a        = ops.a[0];
    br.b        = ops.b[0];
    br.rob_slot = ops.rob_slot[0];

    // strictly in order, oldest first; any slot that cannot go ends the walk
    for (int i = 0; i < issue_width; i++) begin
      slot_issue = pack_issue(ops.inst[i], ops.a[i], ops.b[i], ops.rob_slot[i]);
      if (!done) begin
        if (!iq_valid[i] || !ops.ops_ready[i]) begin
          done = 1'b1;
        end else begin
          case (ops.inst[i].op_class)
            op_load, op_store: begin
              if (!ls_used && ls_ready) begin
                ls_used  = 1'b1;
                ls_issue = slot_issue;
                count    = count + 1'b1;
              end else begin
                done = 1'b1;
              end
            end
            op_muldiv: begin
              if (!mul_used && mul_ready) begin
                mul_used  = 1'b1;
                mul_issue = slot_issue;
                count     = count + 1'b1;
              end else begin
                done = 1'b1;
              end
            end
            op_alu: begin
              if (!alu_used && alu_ready) begin
                alu_used  = 1'b1;
                alu_issue = slot_issue;
                count     = count + 1'b1;
              end else if (!mul_used && mul_ready) begin
                // the multiply/divide unit also executes plain ALU ops
                mul_used  = 1'b1;
                mul_issue = slot_issue;
                count     = count + 1'b1;
              end else begin
                done = 1'b1;
              end
            end
            op_branch, op_jump: begin
              if (br.ready) begin
                br_used     = 1'b1;
                br.inst     = ops.inst[i];
                br.a        = ops.a[i];
                br.b        = ops.b[i];
                br.rob_slot = ops.rob_slot[i];
                count       = count + 1'b1;
              end
              // a branch always closes the issue group
              done = 1'b1;
            end
            default: begin
              done = 1'b1;
            end
          endcase
        end
      end
    end

    ls_valid  = ls_used;
    alu_valid = alu_used;
    mul_valid = mul_used;
    br.valid  = br_used;
    iq_pop    = count;
  end

endmodule

//--- src/branch_resolve.sv
`timescale 1ns/1ns

module branch_resolve import iss_pkg::*; (
  input  logic                 clock,
  input  logic                 reset_n,

  // fetch is not ready to take a redirect
  input  logic                 branch_stall,

  output logic [data_w-1:0]    new_pc,
  output logic                 new_pc_valid,

  // link write into the branch's own ROB slot
  output logic                 rob_wr_valid,
  output logic [rob_idx_w-1:0] rob_wr_slot,
  output rob_entry_t           rob_wr_data,

  branch_if.branch             br
);

  logic stall_q;
  logic a_eqz;
  logic a_gez;
  logic a_gtz;
  logic ab_equal;
  logic cond_ok;
  logic is_branch;
  logic is_jump;

  // stall seen at one edge blocks branches for the following cycle
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      stall_q <= 1'b0;
    end else begin
      stall_q <= branch_stall;
    end
  end

  assign br.ready = ~stall_q;

  // compares against zero treat a as signed
  assign a_eqz    = (br.a == '0);
  assign a_gez    = ~br.a[data_w-1];
  assign a_gtz    = a_gez & ~a_eqz;
  assign ab_equal = (br.a == br.b);

  always_comb begin
    case (br.inst.branch_cond)
      cond_uncond: cond_ok = 1'b1;
      cond_eq:     cond_ok = ab_equal;
      cond_ne:     cond_ok = ~ab_equal;
      cond_gt:     cond_ok = a_gtz;
      cond_ge:     cond_ok = a_gez;
      cond_lt:     cond_ok = ~a_gez;
      cond_le:     cond_ok = ~a_gtz;
      default:     cond_ok = 1'b0;
    endcase
  end

  assign is_branch = (br.inst.op_class == op_branch);
  assign is_jump   = (br.inst.op_class == op_jump);

  // register jumps take their target from operand a
  assign new_pc       = br.inst.rformat ? br.a : br.inst.branch_target;
  assign new_pc_valid = br.valid & (is_jump | (is_branch & cond_ok));

  // every issued branch retires through the ROB with its link value
  assign rob_wr_valid               = br.valid;
  assign rob_wr_slot                = br.rob_slot;
  assign rob_wr_data.result         = br.inst.pc + data_w'(link_offset);
  assign rob_wr_data.dest_reg       = br.inst.dest_reg;
  assign rob_wr_data.dest_reg_valid = br.inst.dest_reg_valid;
  assign rob_wr_data.pc_valid       = new_pc_valid;

endmodule

//--- src/iss_top.sv
`timescale 1ns/1ns

module iss_top import iss_pkg::*; (
  input  logic                  clock,
  input  logic                  reset_n,

  // instruction queue, slot 0 is the oldest
  input  logic                  iq_valid      [issue_width],
  input  dec_inst_t             iq_inst       [issue_width],
  input  logic [rob_idx_w-1:0]  iq_rob_slot   [issue_width],
  output logic [pop_w-1:0]      iq_pop,

  // ROB lookup
  input  logic                  rob_present_a [issue_width],
  input  logic                  rob_present_b [issue_width],
  input  logic                  rob_valid_a   [issue_width],
  input  logic                  rob_valid_b   [issue_width],
  input  logic [data_w-1:0]     rob_value_a   [issue_width],
  input  logic [data_w-1:0]     rob_value_b   [issue_width],

  // register file
  output logic [reg_addr_w-1:0] rf_addr       [2*issue_width],
  input  logic [data_w-1:0]     rf_data       [2*issue_width],

  // execution units
  output unit_issue_t           ls_issue,
  output logic                  ls_valid,
  input  logic                  ls_ready,
  output unit_issue_t           alu_issue,
  output logic                  alu_valid,
  input  logic                  alu_ready,
  output unit_issue_t           mul_issue,
  output logic                  mul_valid,
  input  logic                  mul_ready,

  // fetch redirect
  input  logic                  branch_stall,
  output logic [data_w-1:0]     new_pc,
  output logic                  new_pc_valid,

  // ROB write from the branch unit
  output logic                  rob_wr_valid,
  output logic [rob_idx_w-1:0]  rob_wr_slot,
  output rob_entry_t            rob_wr_data
);

  operand_if ops_bus ();
  branch_if  br_bus ();

  operand_resolve u_operand_resolve (
    .iq_inst       (iq_inst),
    .iq_rob_slot   (iq_rob_slot),
    .rob_present_a (rob_present_a),
    .rob_present_b (rob_present_b),
    .rob_valid_a   (rob_valid_a),
    .rob_valid_b   (rob_valid_b),
    .rob_value_a   (rob_value_a),
    .rob_value_b   (rob_value_b),
    .rf_addr       (rf_addr),
    .rf_data       (rf_data),
    .ops           (ops_bus.resolver)
  );

  issue_select u_issue_select (
    .iq_valid  (iq_valid),
    .ls_ready  (ls_ready),
    .alu_ready (alu_ready),
    .mul_ready (mul_ready),
    .ls_issue  (ls_issue),
    .ls_valid  (ls_valid),
    .alu_issue (alu_issue),
    .alu_valid (alu_valid),
    .mul_issue (mul_issue),
    .mul_valid (mul_valid),
    .iq_pop    (iq_pop),
    .ops       (ops_bus.selector),
    .br        (br_bus.selector)
  );

  branch_resolve u_branch_resolve (
    .clock        (clock),
    .reset_n      (reset_n),
    .branch_stall (branch_stall),
    .new_pc       (new_pc),
    .new_pc_valid (new_pc_valid),
    .rob_wr_valid (rob_wr_valid),
    .rob_wr_slot  (rob_wr_slot),
    .rob_wr_data  (rob_wr_data),
    .br           (br_bus.branch)
  );

endmodule

//--- sim/iss_checker.sv
`timescale 1ns/1ns

module iss_checker import iss_pkg::*; (
  input  logic                  clock,
  input  logic                  check_en,
  // expected row
  input  logic [pop_w-1:0]      exp_pop,
  input  logic [3:0]            exp_vld,
  input  logic [data_w-1:0]     exp_a       [issue_width],
  input  logic [data_w-1:0]     exp_b       [issue_width],
  input  logic [rob_idx_w-1:0]  exp_slot    [issue_width],
  input  logic [reg_addr_w-1:0] exp_rf_addr [2*issue_width],
  input  logic [data_w-1:0]     exp_npc,
  input  logic [data_w-1:0]     exp_link,
  input  logic [reg_addr_w:0]   exp_dest,
  input  logic                  exp_br,
  // DUT outputs
  input  logic [pop_w-1:0]      iq_pop,
  input  logic [reg_addr_w-1:0] rf_addr     [2*issue_width],
  input  unit_issue_t           ls_issue,
  input  logic                  ls_valid,
  input  unit_issue_t           alu_issue,
  input  logic                  alu_valid,
  input  unit_issue_t           mul_issue,
  input  logic                  mul_valid,
  input  logic [data_w-1:0]     new_pc,
  input  logic                  new_pc_valid,
  input  logic                  rob_wr_valid,
  input  logic [rob_idx_w-1:0]  rob_wr_slot,
  input  rob_entry_t            rob_wr_data,
  output int                    errors
);

  initial errors = 0;

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("Fail %0t %s expected %h actual %h", $time, name, exp, got);
      errors++;
    end
  endtask

  // payload of a unit that took queue slot k
  task automatic check_unit(input string name, input unit_issue_t u, input int k);
    compare({name, ".a"}, exp_a[k], u.a);
    compare({name, ".b"}, exp_b[k], u.b);
    compare({name, ".rob_slot"}, exp_slot[k], u.rob_slot);
  endtask

  // outputs still hold the row driven at the falling edge
  always @(posedge clock) begin
    int k;
    if (check_en) begin
      compare("iq_pop", exp_pop, iq_pop);
      compare("ls_valid", exp_vld[3], ls_valid);
      compare("alu_valid", exp_vld[2], alu_valid);
      compare("mul_valid", exp_vld[1], mul_valid);
      compare("new_pc_valid", exp_vld[0], new_pc_valid);
      compare("rob_wr_valid", exp_br, rob_wr_valid);
      for (int j = 0; j < 2*issue_width; j++) begin
        compare($sformatf("rf_addr[%0d]", j), exp_rf_addr[j], rf_addr[j]);
      end
      // issued units in ls, alu, mul order take slot 0 and then slot 1
      k = 0;
      if (exp_vld[3]) begin
        check_unit("ls_issue", ls_issue, k);
        k++;
      end
      if (exp_vld[2]) begin
        check_unit("alu_issue", alu_issue, k);
        k++;
      end
      if (exp_vld[1]) begin
        check_unit("mul_issue", mul_issue, k);
      end
      if (exp_vld[0]) compare("new_pc", exp_npc, new_pc);
      if (exp_br) begin
        compare("rob_wr_slot", exp_slot[0], rob_wr_slot);
        compare("rob_wr_data.result", exp_link, rob_wr_data.result);
        compare("rob_wr_data.dest_reg", exp_dest[reg_addr_w:1], rob_wr_data.dest_reg);
        compare("rob_wr_data.dest_reg_valid", exp_dest[0], rob_wr_data.dest_reg_valid);
        compare("rob_wr_data.pc_valid", exp_vld[0], rob_wr_data.pc_valid);
      end
    end
  end

endmodule

//--- sim/iss_sva.sv
`timescale 1ns/1ns

module iss_sva import iss_pkg::*; (
  input logic             clock,
  input logic             reset_n,
  input logic             iq_valid [issue_width],
  input dec_inst_t        iq_inst  [issue_width],
  input logic [pop_w-1:0] iq_pop,
  input logic             ls_valid,
  input logic             ls_ready,
  input logic             alu_valid,
  input logic             alu_ready,
  input logic             mul_valid,
  input logic             mul_ready,
  input logic             new_pc_valid,
  input logic             rob_wr_valid
);

  logic [pop_w-1:0] lead_valid;
  logic             br_class [issue_width];

  // count of valid slots before the first hole
  assign lead_valid = iq_valid[0] ? (iq_valid[1] ? 2'd2 : 2'd1) : 2'd0;

  for (genvar i = 0; i < issue_width; i++) begin : g_class
    assign br_class[i] = (iq_inst[i].op_class == op_branch)
                       || (iq_inst[i].op_class == op_jump);
  end

  a_pop_bound: assert property (@(posedge clock) disable iff (!reset_n)
    iq_pop <= lead_valid) else $error("pop count above leading valid slots");

  a_unit_ready: assert property (@(posedge clock) disable iff (!reset_n)
    (!ls_valid || ls_ready) && (!alu_valid || alu_ready) && (!mul_valid || mul_ready))
    else $error("issue to a unit that is not ready");

  // a redirect or link write needs a branch as the last entry popped
  a_redirect: assert property (@(posedge clock) disable iff (!reset_n)
    (new_pc_valid || rob_wr_valid) |->
      ((iq_pop == 2'd1) && br_class[0]) || ((iq_pop == 2'd2) && br_class[1]))
    else $error("redirect or link write without an issued branch");

endmodule

//--- sim/iss_tb.sv
`timescale 1ns/1ns

module iss_tb import iss_pkg::*; ();

  typedef struct {
    logic         v0;
    op_class_e    c0;
    branch_cond_e cond;
    logic         rf;
    logic [1:0]   src;
    logic [31:0]  a;
    logic [31:0]  b;
    op_class_e    c1;
    logic [2:0]   rdy;
    logic         stall;
    logic [1:0]   pop;
    logic [3:0]   vld;
  } row_t;

  logic clock, reset_n, branch_stall, ls_ready, alu_ready, mul_ready;
  logic iq_valid [issue_width];
  dec_inst_t iq_inst [issue_width];
  logic [rob_idx_w-1:0] iq_rob_slot [issue_width];
  logic rob_present_a [issue_width], rob_present_b [issue_width];
  logic rob_valid_a [issue_width], rob_valid_b [issue_width];
  logic [data_w-1:0] rob_value_a [issue_width], rob_value_b [issue_width];
  logic [reg_addr_w-1:0] rf_addr [2*issue_width];
  logic [data_w-1:0] rf_data [2*issue_width];
  logic [pop_w-1:0] iq_pop;
  unit_issue_t ls_issue, alu_issue, mul_issue;
  logic ls_valid, alu_valid, mul_valid, new_pc_valid, rob_wr_valid;
  logic [data_w-1:0] new_pc;
  logic [rob_idx_w-1:0] rob_wr_slot;
  rob_entry_t rob_wr_data;

  logic check_en, exp_br;
  logic [pop_w-1:0] exp_pop;
  logic [3:0] exp_vld;
  logic [data_w-1:0] exp_a [issue_width];
  logic [data_w-1:0] exp_b [issue_width];
  logic [rob_idx_w-1:0] exp_slot [issue_width];
  logic [reg_addr_w-1:0] exp_rf_addr [2*issue_width];
  logic [data_w-1:0] exp_npc, exp_link;
  logic [reg_addr_w:0] exp_dest;
  int errors, cycles, limit;
  integer seed = 32'heead93ad;
  logic [31:0] r0, r1;
  row_t rows [$];

  iss_top DUT (.*);

  iss_checker u_checker (.*);

  bind iss_top iss_sva u_sva (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic row_t mk(logic v0, op_class_e c0, branch_cond_e cond, logic rf,
      logic [1:0] src, logic [31:0] a, logic [31:0] b, op_class_e c1, logic [2:0] rdy,
      logic stall, logic [1:0] pop, logic [3:0] vld);
    row_t r;
    r = '{v0, c0, cond, rf, src, a, b, c1, rdy, stall, pop, vld};
    return r;
  endfunction

  // src 0 reads the register file, 1 a valid ROB hit, 2 a pending ROB entry
  task automatic drive(input row_t r);
    logic [31:0] pc;
    logic [31:0] tgt;
    logic [reg_addr_w:0] dst;
    pc  = $random(seed) & 32'hffff_fffc;
    tgt = $random(seed) & 32'hffff_fffc;
    dst = (reg_addr_w+1)'($random(seed));
    for (int i = 0; i < issue_width; i++) begin
      iq_inst[i] = '{pc: pc + 4*i, branch_target: tgt, op_class: (i == 0) ? r.c0 : r.c1,
                     branch_cond: r.cond, rformat: r.rf, a_reg: 5'(2*i + 1), a_reg_valid: 1'b1,
                     b_reg: 5'(2*i + 2), b_reg_valid: 1'b1, dest_reg: dst[reg_addr_w:1],
                     dest_reg_valid: dst[0]};
      iq_rob_slot[i] = 4'($random(seed));
      rob_value_a[i] = $random(seed);
      rob_value_b[i] = $random(seed);
      rob_present_a[i] = 1'b0;
      rob_present_b[i] = 1'b0;
      rob_valid_a[i] = 1'b0;
      rob_valid_b[i] = 1'b0;
      rf_data[2*i] = $random(seed);
      rf_data[2*i+1] = $random(seed);
      exp_rf_addr[2*i]   = iq_inst[i].a_reg;
      exp_rf_addr[2*i+1] = iq_inst[i].b_reg;
    end
    iq_valid[0] = r.v0;
    iq_valid[1] = 1'b1;
    rf_data[1] = r.b;
    if (r.src == 2'd0) rf_data[0] = r.a;
    else rob_value_a[0] = r.a;
    rob_present_a[0] = (r.src != 2'd0);
    rob_valid_a[0] = (r.src == 2'd1);
    {ls_ready, alu_ready, mul_ready} = r.rdy;
    branch_stall = r.stall;
    exp_pop  = r.pop;
    exp_vld  = r.vld;
    // slot 1 operands never hit the ROB
    exp_a[0] = r.a;
    exp_a[1] = rf_data[2];
    exp_b[0] = r.b;
    exp_b[1] = rf_data[3];
    exp_slot[0] = iq_rob_slot[0];
    exp_slot[1] = iq_rob_slot[1];
    exp_npc  = r.rf ? r.a : tgt;
    exp_link = pc + 32'd8;
    exp_dest = dst;
    exp_br   = (r.c0 == op_branch || r.c0 == op_jump) && (r.pop != 2'd0);
  endtask

  always @(posedge clock) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout, run did not finish within %0d cycles", limit);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    r0 = $random(seed);
    r1 = $random(seed);
    // vld columns are ls, alu, mul, new_pc_valid
    rows.push_back(mk(1, op_alu, cond_uncond, 0, 0, r0, r1, op_muldiv, 3'b111, 0, 2, 4'b0110));
    rows.push_back(mk(1, op_alu, cond_uncond, 0, 1, r1, r0, op_alu, 3'b111, 0, 2, 4'b0110));
    rows.push_back(mk(1, op_alu, cond_uncond, 0, 2, r0, r1, op_alu, 3'b111, 0, 0, 4'b0000));
    rows.push_back(mk(1, op_load, cond_uncond, 0, 0, r1, r0, op_alu, 3'b111, 0, 2, 4'b1100));
    rows.push_back(mk(1, op_muldiv, cond_uncond, 0, 1, r0, r0, op_muldiv, 3'b111, 0, 1, 4'b0010));
    rows.push_back(mk(1, op_load, cond_uncond, 0, 0, r0, r1, op_alu, 3'b011, 0, 0, 4'b0000));
    rows.push_back(mk(0, op_alu, cond_uncond, 0, 0, r0, r1, op_alu, 3'b111, 0, 0, 4'b0000));
    rows.push_back(mk(1, op_branch, cond_eq, 0, 0, 5, 5, op_alu, 3'b111, 0, 1, 4'b0001));
    rows.push_back(mk(1, op_branch, cond_eq, 0, 1, 5, 6, op_alu, 3'b111, 0, 1, 4'b0000));
    rows.push_back(mk(1, op_branch, cond_ne, 0, 0, 5, 6, op_alu, 3'b111, 0, 1, 4'b0001));
    rows.push_back(mk(1, op_branch, cond_ne, 0, 0, 7, 7, op_alu, 3'b111, 0, 1, 4'b0000));
    rows.push_back(mk(1, op_branch, cond_gt, 0, 0, 1, r0, op_alu, 3'b111, 0, 1, 4'b0001));
    rows.push_back(mk(1, op_branch, cond_gt, 0, 1, 0, r0, op_alu, 3'b111, 0, 1, 4'b0000));
    rows.push_back(mk(1, op_branch, cond_ge, 0, 0, 0, r1, op_alu, 3'b111, 0, 1, 4'b0001));
    rows.push_back(mk(1, op_branch, cond_ge, 0, 0, -1, r1, op_alu, 3'b111, 0, 1, 4'b0000));
    rows.push_back(mk(1, op_branch, cond_lt, 0, 0, -2, r0, op_alu, 3'b111, 0, 1, 4'b0001));
    rows.push_back(mk(1, op_branch, cond_lt, 0, 0, 0, r0, op_alu, 3'b111, 0, 1, 4'b0000));
    rows.push_back(mk(1, op_branch, cond_le, 0, 0, 0, r1, op_alu, 3'b111, 0, 1, 4'b0001));
    rows.push_back(mk(1, op_branch, cond_le, 0, 0, 3, r1, op_alu, 3'b111, 0, 1, 4'b0000));
    rows.push_back(mk(1, op_branch, cond_uncond, 0, 0, r0, r1, op_alu, 3'b111, 0, 1, 4'b0001));
    rows.push_back(mk(1, op_jump, cond_eq, 1, 1, r1, r0, op_alu, 3'b111, 0, 1, 4'b0001));
    // stall in one row holds back the branch in the next
    rows.push_back(mk(1, op_alu, cond_uncond, 0, 0, r0, r1, op_alu, 3'b111, 1, 2, 4'b0110));
    rows.push_back(mk(1, op_branch, cond_uncond, 0, 0, r0, r1, op_alu, 3'b111, 0, 0, 4'b0000));
    rows.push_back(mk(1, op_branch, cond_uncond, 0, 0, r1, r0, op_alu, 3'b111, 0, 1, 4'b0001));
    limit = 16 + rows.size() + 20;
    cycles = 0;
    check_en = 1'b0;
    reset_n = 1'b0;
    drive(rows[0]);
    iq_valid[0] = 1'b0;
    iq_valid[1] = 1'b0;
    branch_stall = 1'b0;
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;
    foreach (rows[i]) begin
      @(negedge clock);
      drive(rows[i]);
      check_en = 1'b1;
    end
    @(negedge clock);
    check_en = 1'b0;
    iq_valid[0] = 1'b0;
    iq_valid[1] = 1'b0;
    @(negedge clock);
    $display("rows %0d, errors %0d", rows.size(), errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
src/iss_pkg.sv
src/operand_if.sv
src/branch_if.sv
src/operand_resolve.sv
src/issue_select.sv
src/branch_resolve.sv
src/iss_top.sv
sim/iss_checker.sv
sim/iss_sva.sv
sim/iss_tb.sv

//--- Bender.yml
package:
  name: iss

sources:
  - src/iss_pkg.sv
  - src/operand_if.sv
  - src/branch_if.sv
  - src/operand_resolve.sv
  - src/issue_select.sv
  - src/branch_resolve.sv
  - src/iss_top.sv
  - target: simulation
    files:
      - sim/iss_checker.sv
      - sim/iss_sva.sv
      - sim/iss_tb.sv
